/* bench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// x1 and x2 hold the two loaded words, x3 carries each result to its store
task automatic load_program();
    imem[0] = imm_instr(cpu_pkg::op_load, cpu_pkg::f3_word, 5'd1, 5'd0, 12'd0);
    imem[1] = imm_instr(cpu_pkg::op_load, cpu_pkg::f3_word, 5'd2, 5'd0, 12'd4);
    imem[2] = reg_instr(cpu_pkg::f3_add, 7'b0, 5'd3, 5'd1, 5'd2);
    imem[3] = store_instr(5'd3, 5'd0, 12'd16);
    imem[4] = reg_instr(cpu_pkg::f3_add, cpu_pkg::funct7_sub, 5'd3, 5'd1, 5'd2);
    imem[5] = store_instr(5'd3, 5'd0, 12'd20);
    imem[6] = reg_instr(cpu_pkg::f3_and, 7'b0, 5'd3, 5'd1, 5'd2);
    imem[7] = store_instr(5'd3, 5'd0, 12'd24);
    imem[8] = reg_instr(cpu_pkg::f3_or, 7'b0, 5'd3, 5'd1, 5'd2);
    imem[9] = store_instr(5'd3, 5'd0, 12'd28);
    imem[10] = reg_instr(cpu_pkg::f3_xor, 7'b0, 5'd3, 5'd1, 5'd2);
    imem[11] = store_instr(5'd3, 5'd0, 12'd32);
    imem[12] = reg_instr(cpu_pkg::f3_slt, 7'b0, 5'd3, 5'd1, 5'd2);
    imem[13] = store_instr(5'd3, 5'd0, 12'd36);
    imem[14] = imm_instr(cpu_pkg::op_imm_arith, cpu_pkg::f3_add, 5'd3, 5'd1, 12'hedd);
    imem[15] = store_instr(5'd3, 5'd0, 12'd40);
    imem[16] = imm_instr(cpu_pkg::op_imm_arith, cpu_pkg::f3_and, 5'd3, 5'd1, 12'h5a5);
    imem[17] = store_instr(5'd3, 5'd0, 12'd44);
    imem[18] = imm_instr(cpu_pkg::op_imm_arith, cpu_pkg::f3_or, 5'd3, 5'd1, 12'h0f0);
    imem[19] = store_instr(5'd3, 5'd0, 12'd48);
    imem[20] = imm_instr(cpu_pkg::op_imm_arith, cpu_pkg::f3_xor, 5'd3, 5'd1, 12'hfff);
    imem[21] = store_instr(5'd3, 5'd0, 12'd52);
    imem[22] = imm_instr(cpu_pkg::op_imm_arith, cpu_pkg::f3_slt, 5'd3, 5'd1, 12'h800);
    imem[23] = store_instr(5'd3, 5'd0, 12'd56);
    imem[24] = lui_instr(5'd3, 20'habcde);
    imem[25] = store_instr(5'd3, 5'd0, 12'd60);
    imem[26] = imm_instr(cpu_pkg::op_imm_arith, cpu_pkg::f3_add, 5'd0, 5'd1, 12'd1);
    imem[27] = store_instr(5'd0, 5'd0, 12'd64);
    imem[28] = store_instr(5'd1, 5'd0, 12'd68);
    imem[29] = branch_instr(cpu_pkg::f3_beq, 5'd1, 5'd1, 13'd8);
    imem[30] = store_instr(5'd1, 5'd0, 12'd72); // skipped by the beq
    imem[31] = branch_instr(cpu_pkg::f3_bne, 5'd1, 5'd1, 13'd8);
    imem[32] = jal_instr(5'd5, 21'd8);
    imem[33] = store_instr(5'd1, 5'd0, 12'd76); // skipped by the jal
    imem[34] = store_instr(5'd5, 5'd0, 12'd80);
    imem[35] = jal_instr(5'd0, 21'd0);
endtask

`endif

/* bench/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;

    localparam int mem_words = 64;
    localparam int retire_timeout = 20; // cycles, one instruction takes 6
    localparam int max_retires = 64;
    localparam cpu_pkg::word_t beq_pc = 32'd116;
    localparam cpu_pkg::word_t jal_pc = 32'd128;
    localparam cpu_pkg::word_t end_pc = 32'd140;
    localparam cpu_pkg::word_t beq_skipped_pc = 32'd120;
    localparam cpu_pkg::word_t jal_skipped_pc = 32'd132;

    logic clk = 1'b0;
    logic rst;
    cpu_pkg::word_t instr_addr;
    cpu_pkg::word_t instr_data;
    cpu_pkg::word_t data_addr;
    cpu_pkg::word_t data_wdata;
    logic data_write;
    logic data_read;
    cpu_pkg::word_t data_rdata;
    logic retire;
    cpu_pkg::word_t retire_pc;

    cpu_pkg::word_t imem [mem_words];
    cpu_pkg::word_t dmem [mem_words];
    cpu_pkg::word_t store_value [mem_words];
    logic store_expected [mem_words];
    logic store_written [mem_words];

    logic check_armed = 1'b0;
    logic release_now;
    int releases;
    cpu_pkg::word_t expected_pc;
    int mismatch_count = 0;
    int failure_count = 0;

    always #10 clk = ~clk;

    five_cycle_cpu DUT (
        .clk ( clk ),
        .rst ( rst ),
        .instr_addr ( instr_addr ),
        .instr_data ( instr_data ),
        .data_addr ( data_addr ),
        .data_wdata ( data_wdata ),
        .data_write ( data_write ),
        .data_read ( data_read ),
        .data_rdata ( data_rdata ),
        .retire ( retire ),
        .retire_pc ( retire_pc )
    );

    // both memories answer in the same cycle, data memory only on a read
    assign instr_data = imem[instr_addr[7:2]];
    assign data_rdata = data_read ? dmem[data_addr[7:2]] : '0;

    always @(posedge clk) begin
        if (data_write) begin
            dmem[data_addr[7:2]] <= data_wdata;
            store_written[data_addr[7:2]] <= 1'b1;
        end
    end

    function automatic cpu_pkg::word_t reg_instr(input logic [2:0] funct3,
            input logic [6:0] funct7, input cpu_pkg::reg_addr_t rd,
            input cpu_pkg::reg_addr_t rs1, input cpu_pkg::reg_addr_t rs2);
        cpu_pkg::instr_u w;
        w.r.opcode = cpu_pkg::op_reg_arith;
        w.r.rd = rd;
        w.r.funct3 = funct3;
        w.r.rs1 = rs1;
        w.r.rs2 = rs2;
        w.r.funct7 = funct7;
        return w;
    endfunction

    function automatic cpu_pkg::word_t imm_instr(input logic [6:0] opcode,
            input logic [2:0] funct3, input cpu_pkg::reg_addr_t rd,
            input cpu_pkg::reg_addr_t rs1, input logic [11:0] imm);
        cpu_pkg::instr_u w;
        w.i.opcode = opcode;
        w.i.rd = rd;
        w.i.funct3 = funct3;
        w.i.rs1 = rs1;
        w.i.imm = imm;
        return w;
    endfunction

    function automatic cpu_pkg::word_t store_instr(input cpu_pkg::reg_addr_t rs2,
            input cpu_pkg::reg_addr_t rs1, input logic [11:0] imm);
        cpu_pkg::instr_u w;
        w.s.opcode = cpu_pkg::op_store;
        w.s.funct3 = cpu_pkg::f3_word;
        w.s.rs1 = rs1;
        w.s.rs2 = rs2;
        w.s.imm_hi = imm[11:5];
        w.s.imm_lo = imm[4:0];
        return w;
    endfunction

    function automatic cpu_pkg::word_t branch_instr(input logic [2:0] funct3,
            input cpu_pkg::reg_addr_t rs1, input cpu_pkg::reg_addr_t rs2,
            input logic [12:0] offset);
        cpu_pkg::instr_u w;
        w.s.opcode = cpu_pkg::op_branch;
        w.s.funct3 = funct3;
        w.s.rs1 = rs1;
        w.s.rs2 = rs2;
        w.s.imm_hi = {offset[12], offset[10:5]};
        w.s.imm_lo = {offset[4:1], offset[11]}; // b-type scrambles bit 11 into the low field
        return w;
    endfunction

    function automatic cpu_pkg::word_t jal_instr(input cpu_pkg::reg_addr_t rd,
            input logic [20:0] offset);
        cpu_pkg::instr_u w;
        w.u.opcode = cpu_pkg::op_jal;
        w.u.rd = rd;
        w.u.imm = {offset[20], offset[10:1], offset[11], offset[19:12]};
        return w;
    endfunction

    function automatic cpu_pkg::word_t lui_instr(input cpu_pkg::reg_addr_t rd,
            input logic [19:0] upper);
        cpu_pkg::instr_u w;
        w.u.opcode = cpu_pkg::op_lui;
        w.u.rd = rd;
        w.u.imm = upper;
        return w;
    endfunction

    `include "tb_program.svh"

    function automatic cpu_pkg::word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic cpu_pkg::word_t next_after(input cpu_pkg::word_t pc);
        case (pc)
            beq_pc:  return beq_pc + 32'd8; // beq x1, x1 always branches
            jal_pc:  return jal_pc + 32'd8;
            end_pc:  return end_pc;         // final jump to itself
            default: return pc + cpu_pkg::pc_step;
        endcase
    endfunction

    task automatic expect_store(input int addr, input cpu_pkg::word_t value);
        store_expected[addr / 4] = 1'b1;
        store_value[addr / 4] = value;
    endtask

    task automatic wait_retire(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < retire_timeout) begin
            @(posedge clk);
            seen = retire;
            n++;
        end
    endtask

    always @(posedge clk) check_armed <= 1'b1;

    assign release_now = DUT.pc_to_fetch.done && !DUT.pc_to_fetch.stall;

    always @(posedge clk) begin
        if (!rst) begin
            releases <= 0;
            expected_pc <= cpu_pkg::reset_pc;
        end else if (retire) begin
            releases <= int'(release_now);
            expected_pc <= next_after(retire_pc);
        end else begin
            releases <= releases + int'(release_now);
        end
    end

    reset_quiet: assert property (@(posedge clk)
        check_armed && (!rst || $past(!rst)) |-> !data_write && !data_read && !retire)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: memory port or retire active around reset", $time);
        end

    first_fetch_at_reset_pc: assert property (@(posedge clk)
        check_armed && rst && $past(!rst) |-> instr_addr == cpu_pkg::reset_pc)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: first instr_addr %h", $time, $sampled(instr_addr));
        end

    store_data_matches: assert property (@(posedge clk) disable iff (!rst)
        data_write |-> store_expected[data_addr[7:2]]
                       && data_wdata == store_value[data_addr[7:2]])
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: store to %h carried %h, expected %h", $time,
                     $sampled(data_addr), $sampled(data_wdata),
                     store_value[$sampled(data_addr[7:2])]);
        end

    retire_in_order: assert property (@(posedge clk) disable iff (!rst)
        retire |-> retire_pc == expected_pc)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: retired pc %h, expected %h", $time,
                     $sampled(retire_pc), $sampled(expected_pc));
        end

    skipped_paths_idle: assert property (@(posedge clk) disable iff (!rst)
        retire |-> retire_pc != beq_skipped_pc && retire_pc != jal_skipped_pc)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: skipped pc %h retired", $time, $sampled(retire_pc));
        end

    one_release_per_retire: assert property (@(posedge clk) disable iff (!rst)
        retire |-> releases == 1)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: %0d pc releases before this retire", $time,
                     $sampled(releases));
        end

    no_read_with_write: assert property (@(posedge clk) disable iff (!rst)
        !(data_write && data_read))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: data_write and data_read both high", $time);
        end

    // the program loads only the two words at 0 and 4
    reads_hit_loaded_words: assert property (@(posedge clk) disable iff (!rst)
        data_read |-> data_addr == 32'd0 || data_addr == 32'd4)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: read from %h outside the loaded words", $time,
                     $sampled(data_addr));
        end

    initial begin
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        bit seen;
        bit finished;
        int retired;
        void'($urandom(33338));
        rst = 1'b0;
        a = $urandom();
        b = $urandom();
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = imm_instr(cpu_pkg::op_imm_arith, cpu_pkg::f3_add, 5'd0, 5'd0,
                                12'(i * 4)); // no-op fill, tagged with its address
            dmem[i] = 32'hdada_0000 | 32'(i * 4);
            store_expected[i] = 1'b0;
            store_value[i] = '0;
            store_written[i] = 1'b0;
        end
        dmem[0] = a;
        dmem[1] = b;
        load_program();

        expect_store(16, a + b);
        expect_store(20, a - b);
        expect_store(24, a & b);
        expect_store(28, a | b);
        expect_store(32, a ^ b);
        expect_store(36, {31'b0, $signed(a) < $signed(b)});
        expect_store(40, a + sext12(12'hedd));
        expect_store(44, a & sext12(12'h5a5));
        expect_store(48, a | sext12(12'h0f0));
        expect_store(52, a ^ sext12(12'hfff));
        expect_store(56, {31'b0, $signed(a) < $signed(sext12(12'h800))});
        expect_store(60, {20'habcde, 12'b0});
        expect_store(64, '0);             // x0 after the addi into it
        expect_store(68, a);              // round trip of the first load
        expect_store(80, jal_pc + 32'd4); // jal link register

        repeat (4) @(posedge clk);
        rst <= 1'b1;

        finished = 1'b0;
        seen = 1'b1;
        retired = 0;
        while (!finished && seen && retired < max_retires) begin
            wait_retire(seen);
            if (seen) begin
                retired++;
                finished = retire_pc == end_pc;
            end
        end
        if (!seen) begin
            failure_count++;
            $display("timeout: no instruction retired within %0d cycles", retire_timeout);
        end else if (!finished) begin
            failure_count++;
            $display("program never reached its final jump after %0d retires", retired);
        end

        repeat (2) @(posedge clk); // let the last assertions settle
        for (int i = 0; i < mem_words; i++) begin
            if (store_expected[i] && !store_written[i]) begin
                failure_count++;
                $display("no store ever reached address %0d", i * 4);
            end
        end

        $display("errors: %0d mismatches, %0d other failures, %0d instructions retired",
                 mismatch_count, failure_count, retired);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    localparam logic [6:0] op_reg_arith = 7'b0110011;
    localparam logic [6:0] op_imm_arith = 7'b0010011;
    localparam logic [6:0] op_load      = 7'b0000011;
    localparam logic [6:0] op_store     = 7'b0100011;
    localparam logic [6:0] op_branch    = 7'b1100011;
    localparam logic [6:0] op_jal       = 7'b1101111;
    localparam logic [6:0] op_lui       = 7'b0110111;

    localparam logic [2:0] f3_add  = 3'b000; // add, sub, addi
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_word = 3'b010; // lw, sw
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    localparam logic [6:0] funct7_sub = 7'b0100000;

    localparam word_t pc_step  = 32'd4;
    localparam word_t reset_pc = 32'd0;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t rs2;
            reg_addr_t rs1;
            logic [2:0] funct3;
            reg_addr_t rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_addr_t rs1;
            logic [2:0] funct3;
            reg_addr_t rd;
            logic [6:0] opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            reg_addr_t rs2;
            reg_addr_t rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s; // b-type offsets are gathered from this view too
        struct packed {
            logic [19:0] imm;
            reg_addr_t rd;
            logic [6:0] opcode;
        } u; // and j-type offsets from this one
    } instr_u;

    typedef enum logic [2:0] {
        reg_arith,
        imm_arith,
        load,
        store,
        branch,
        jal,
        lui,
        none
    } op_kind_e;

    typedef struct packed {
        word_t pc;
        op_kind_e kind;
        logic [2:0] funct3;
        logic funct7_alt;
        word_t operand_a;  // instruction word between fetch and decode
        word_t operand_b;
        word_t store_data; // branch or jump offset for control flow
        reg_addr_t rd;
        logic wb_en;
        word_t result;
        word_t next_pc;
    } stage_payload_t;

endpackage

/* logic/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input logic clk,
    input logic rst,
    stage_if.sink in,
    stage_if.source out,
    output cpu_pkg::reg_addr_t rs1_addr,
    output cpu_pkg::reg_addr_t rs2_addr,
    input cpu_pkg::word_t rs1_data,
    input cpu_pkg::word_t rs2_data
);

    cpu_pkg::instr_u instr;
    cpu_pkg::word_t imm_i;
    cpu_pkg::word_t imm_s;
    cpu_pkg::word_t imm_b;
    cpu_pkg::word_t imm_j;
    cpu_pkg::word_t imm_u;
    cpu_pkg::stage_payload_t decoded;
    cpu_pkg::stage_payload_t held;
    logic full;
    logic take;

    assign instr = in.payload.operand_a;
    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;

    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0],
                    instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
    assign imm_j = {{12{instr.u.imm[19]}}, instr.u.imm[7:0], instr.u.imm[8],
                    instr.u.imm[18:9], 1'b0};
    assign imm_u = {instr.u.imm, 12'b0};

    always_comb begin
        decoded = '0;
        decoded.pc = in.payload.pc;
        decoded.funct3 = instr.r.funct3;
        decoded.rd = instr.r.rd;
        decoded.operand_a = rs1_data;
        decoded.store_data = rs2_data;
        case (instr.r.opcode)
            cpu_pkg::op_reg_arith: begin
                decoded.kind = cpu_pkg::reg_arith;
                decoded.funct7_alt = instr.r.funct7 == cpu_pkg::funct7_sub;
                decoded.operand_b = rs2_data;
                decoded.wb_en = 1'b1;
            end
            cpu_pkg::op_imm_arith: begin
                decoded.kind = cpu_pkg::imm_arith;
                decoded.operand_b = imm_i;
                decoded.wb_en = 1'b1;
            end
            cpu_pkg::op_load: begin
                decoded.kind = cpu_pkg::load;
                decoded.operand_b = imm_i;
                decoded.wb_en = 1'b1;
            end
            cpu_pkg::op_store: begin
                decoded.kind = cpu_pkg::store;
                decoded.operand_b = imm_s;
            end
            cpu_pkg::op_branch: begin
                decoded.kind = cpu_pkg::branch;
                decoded.operand_b = rs2_data;
                decoded.store_data = imm_b;
            end
            cpu_pkg::op_jal: begin
                decoded.kind = cpu_pkg::jal;
                decoded.store_data = imm_j;
                decoded.wb_en = 1'b1;
            end
            cpu_pkg::op_lui: begin
                decoded.kind = cpu_pkg::lui;
                decoded.operand_b = imm_u;
                decoded.wb_en = 1'b1;
            end
            default: decoded.kind = cpu_pkg::none; // retires as a no-op
        endcase
    end

    assign in.stall = full && out.stall;
    assign take = in.done && !in.stall;

    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (!out.stall) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held <= decoded;
        end
    end

    assign out.done = full;
    assign out.payload = held;

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input logic clk,
    input logic rst,
    stage_if.sink in,
    stage_if.source out
);

    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t alu_out;
    cpu_pkg::word_t seq_pc;
    logic taken;
    cpu_pkg::stage_payload_t executed;
    cpu_pkg::stage_payload_t held;
    logic full;
    logic take;

    assign a = in.payload.operand_a;
    assign b = in.payload.operand_b;
    assign seq_pc = in.payload.pc + cpu_pkg::pc_step;

    always_comb begin
        case (in.payload.funct3)
            cpu_pkg::f3_add: alu_out = in.payload.funct7_alt ? a - b : a + b;
            cpu_pkg::f3_slt: alu_out = {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::f3_xor: alu_out = a ^ b;
            cpu_pkg::f3_or:  alu_out = a | b;
            cpu_pkg::f3_and: alu_out = a & b;
            default:         alu_out = '0; // shifts and sltu are not supported
        endcase
    end

    always_comb begin
        taken = 1'b0;
        if (in.payload.kind == cpu_pkg::jal) begin
            taken = 1'b1;
        end else if (in.payload.kind == cpu_pkg::branch) begin
            taken = (in.payload.funct3 == cpu_pkg::f3_beq && a == b)
                 || (in.payload.funct3 == cpu_pkg::f3_bne && a != b);
        end
    end

    always_comb begin
        executed = in.payload;
        case (in.payload.kind)
            cpu_pkg::reg_arith,
            cpu_pkg::imm_arith: executed.result = alu_out;
            cpu_pkg::load,
            cpu_pkg::store:     executed.result = a + b; // effective address
            cpu_pkg::lui:       executed.result = b;
            cpu_pkg::jal:       executed.result = seq_pc; // link value
            default:            executed.result = '0;
        endcase
        executed.next_pc = taken ? in.payload.pc + in.payload.store_data : seq_pc;
    end

    assign in.stall = full && out.stall;
    assign take = in.done && !in.stall;

    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (!out.stall) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held <= executed;
        end
    end

    assign out.done = full;
    assign out.payload = held;

    next_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst)
        out.done |-> out.payload.next_pc[1:0] == 2'b00
    );

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage (
    input logic clk,
    input logic rst,
    stage_if.sink in,
    stage_if.source out,
    output cpu_pkg::word_t instr_addr,
    input cpu_pkg::word_t instr_data
);

    cpu_pkg::instr_u fetched;
    cpu_pkg::stage_payload_t fetched_item;
    cpu_pkg::stage_payload_t held;
    logic full;
    logic take;

    assign instr_addr = in.payload.pc; // memory answers in the same cycle
    assign fetched = instr_data;

    assign in.stall = full && out.stall;
    assign take = in.done && !in.stall;

    always_comb begin
        fetched_item = '0;
        fetched_item.pc = in.payload.pc;
        fetched_item.operand_a = fetched;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (!out.stall) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held <= fetched_item;
        end
    end

    assign out.done = full;
    assign out.payload = held;

endmodule

/* logic/five_cycle_cpu.sv */
`timescale 1ns/1ns

module five_cycle_cpu (
    input logic clk,
    input logic rst,
    output cpu_pkg::word_t instr_addr,
    input cpu_pkg::word_t instr_data,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_wdata,
    output logic data_write,
    output logic data_read,
    input cpu_pkg::word_t data_rdata,
    output logic retire,
    output cpu_pkg::word_t retire_pc
);

    cpu_pkg::reg_addr_t rs1_addr;
    cpu_pkg::reg_addr_t rs2_addr;
    cpu_pkg::word_t rs1_data;
    cpu_pkg::word_t rs2_data;
    cpu_pkg::reg_addr_t rd_addr;
    cpu_pkg::word_t rd_data;
    logic rd_write;
    cpu_pkg::word_t next_pc;

    stage_if pc_to_fetch ();
    stage_if fetch_to_decode ();
    stage_if decode_to_execute ();
    stage_if execute_to_memory ();
    stage_if memory_to_writeback ();

    program_counter u_program_counter (
        .clk ( clk ),
        .rst ( rst ),
        .out ( pc_to_fetch.source ),
        .retire ( retire ),
        .next_pc ( next_pc )
    );

    fetch_stage u_fetch_stage (
        .clk ( clk ),
        .rst ( rst ),
        .in ( pc_to_fetch.sink ),
        .out ( fetch_to_decode.source ),
        .instr_addr ( instr_addr ),
        .instr_data ( instr_data )
    );

    decode_stage u_decode_stage (
        .clk ( clk ),
        .rst ( rst ),
        .in ( fetch_to_decode.sink ),
        .out ( decode_to_execute.source ),
        .rs1_addr ( rs1_addr ),
        .rs2_addr ( rs2_addr ),
        .rs1_data ( rs1_data ),
        .rs2_data ( rs2_data )
    );

    execute_stage u_execute_stage (
        .clk ( clk ),
        .rst ( rst ),
        .in ( decode_to_execute.sink ),
        .out ( execute_to_memory.source )
    );

    memory_stage u_memory_stage (
        .clk ( clk ),
        .rst ( rst ),
        .in ( execute_to_memory.sink ),
        .out ( memory_to_writeback.source ),
        .data_addr ( data_addr ),
        .data_wdata ( data_wdata ),
        .data_write ( data_write ),
        .data_read ( data_read ),
        .data_rdata ( data_rdata )
    );

    writeback_stage u_writeback_stage (
        .clk ( clk ),
        .rst ( rst ),
        .in ( memory_to_writeback.sink ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data ),
        .rd_write ( rd_write ),
        .retire ( retire ),
        .next_pc ( next_pc ),
        .retire_pc ( retire_pc )
    );

    register_file u_register_file (
        .clk ( clk ),
        .rst ( rst ),
        .rs1_addr ( rs1_addr ),
        .rs2_addr ( rs2_addr ),
        .rs1_data ( rs1_data ),
        .rs2_data ( rs2_data ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_data ),
        .rd_write ( rd_write )
    );

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage (
    input logic clk,
    input logic rst,
    stage_if.sink in,
    stage_if.source out,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_wdata,
    output logic data_write,
    output logic data_read,
    input cpu_pkg::word_t data_rdata
);

    cpu_pkg::stage_payload_t accessed;
    cpu_pkg::stage_payload_t held;
    logic full;
    logic take;

    assign in.stall = full && out.stall;
    assign take = in.done && !in.stall;

    // data port is driven in the arrival cycle, memory answers combinationally
    assign data_addr = in.payload.result;
    assign data_wdata = in.payload.store_data;
    assign data_write = take && in.payload.kind == cpu_pkg::store;
    assign data_read = take && in.payload.kind == cpu_pkg::load;

    always_comb begin
        accessed = in.payload;
        if (in.payload.kind == cpu_pkg::load) begin
            accessed.result = data_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (!out.stall) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held <= accessed;
        end
    end

    assign out.done = full;
    assign out.payload = held;

    no_read_and_write: assert property (
        @(posedge clk) disable iff (!rst)
        !(data_write && data_read)
    );

endmodule

/* logic/program_counter.sv */
`timescale 1ns/1ns

module program_counter (
    input logic clk,
    input logic rst,
    stage_if.source out,
    input logic retire,
    input cpu_pkg::word_t next_pc
);

    cpu_pkg::word_t pc;
    logic queued; // pc waiting to be released into fetch

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= cpu_pkg::reset_pc;
            queued <= 1'b1;
        end else if (retire) begin
            pc <= next_pc;
            queued <= 1'b1;
        end else if (queued && !out.stall) begin
            queued <= 1'b0; // released, idle until retire
        end
    end

    always_comb begin
        out.done = queued;
        out.payload = '0;
        out.payload.pc = pc; // only the pc travels on this link
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst)
        pc % cpu_pkg::pc_step == '0
    );

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input logic clk,
    input logic rst,
    input cpu_pkg::reg_addr_t rs1_addr,
    input cpu_pkg::reg_addr_t rs2_addr,
    output cpu_pkg::word_t rs1_data,
    output cpu_pkg::word_t rs2_data,
    input cpu_pkg::reg_addr_t rd_addr,
    input cpu_pkg::word_t rd_data,
    input logic rd_write
);

    cpu_pkg::word_t regs [2**cpu_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int idx = 0; idx < 2**cpu_pkg::reg_addr_w; idx++) begin
                regs[idx] <= '0;
            end
        end else if (rd_write && rd_addr != '0) begin // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst)
        (rs1_addr == '0 |-> rs1_data == '0) and (rs2_addr == '0 |-> rs2_data == '0)
    );

endmodule

/* logic/stage_if.sv */
`timescale 1ns/1ns

// done/stall link between neighboring stages
// an item moves on a rising edge with done high and stall low
interface stage_if;

    logic done;
    logic stall;
    cpu_pkg::stage_payload_t payload;

    modport source (
        output done,
        output payload,
        input stall
    );

    modport sink (
        input done,
        input payload,
        output stall
    );

endinterface

/* logic/writeback_stage.sv */
`timescale 1ns/1ns

module writeback_stage (
    input logic clk,
    input logic rst,
    stage_if.sink in,
    output cpu_pkg::reg_addr_t rd_addr,
    output cpu_pkg::word_t rd_data,
    output logic rd_write,
    output logic retire,
    output cpu_pkg::word_t next_pc,
    output cpu_pkg::word_t retire_pc
);

    assign in.stall = 1'b0; // last stage, always ready

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_write <= 1'b0;
            retire <= 1'b0;
        end else begin
            rd_write <= in.done && in.payload.wb_en;
            retire <= in.done; // one cycle pulse per instruction
        end
    end

    always_ff @(posedge clk) begin
        if (in.done) begin
            rd_addr <= in.payload.rd;
            rd_data <= in.payload.result;
            next_pc <= in.payload.next_pc;
            retire_pc <= in.payload.pc;
        end
    end

endmodule

/* sources.f */
logic/cpu_pkg.sv
logic/stage_if.sv
logic/register_file.sv
logic/program_counter.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/five_cycle_cpu.sv
bench/cpu_tb.sv
+incdir+bench
